//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = sram_ctrl_tb
FILELIST  = sram_ctrl_top.f

SIM_BIN   = obj_dir/V$(TOP)
PASS_MSG  = No errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

//--- logic/sram_cmd_pkg.sv
package sram_cmd_pkg;

  // sequencer state, one access cycle follows every acceptance
  typedef enum logic [1:0] {
    seq_idle  = 2'd0,
    seq_read  = 2'd1,
    seq_write = 2'd2
  } seq_state_t;

  // edges from read acceptance to response valid with an empty FIFO
  parameter int read_latency = 3;

  // access state entered for an accepted command
  function automatic seq_state_t access_state(input logic wr_en);
    return wr_en ? seq_write : seq_read;
  endfunction

  function automatic logic is_access(input seq_state_t state);
    return state != seq_idle;
  endfunction

  function automatic logic is_write(input seq_state_t state);
    return state == seq_write;
  endfunction

endpackage

//--- logic/sram_cmd_seq.sv
`timescale 1ns/1ps

module sram_cmd_seq #(
  parameter int addr_width = sram_geom_pkg::default_addr_width,
  parameter int data_width = sram_geom_pkg::default_data_width
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  input  logic [addr_width-1:0] cmd_addr,
  input  logic                  cmd_wr_en,
  input  logic [data_width-1:0] cmd_wr_data,

  input  logic                  fifo_half_full,

  output logic [addr_width-1:0] pad_addr,
  output logic [data_width-1:0] pad_wr_data,
  output logic                  pad_wr_en,
  output logic                  pad_we_n,
  output logic                  pad_oe_n
);
  import sram_cmd_pkg::*;

  seq_state_t state;
  seq_state_t state_next;
  logic       accept;

  // only take a command when idle and the response FIFO has room
  assign cmd_ready = (state == seq_idle) && !fifo_half_full;
  assign accept    = cmd_valid && cmd_ready;

  always_comb begin
    state_next = state;
    case (state)
      seq_idle: begin
        if (accept) begin
          state_next = access_state(cmd_wr_en);
        end
      end
      seq_read: begin
        state_next = seq_idle;
      end
      seq_write: begin
        state_next = seq_idle;
      end
      default: begin
        state_next = seq_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= seq_idle;
    end else begin
      state <= state_next;
    end
  end

  // address and write data toward the pads
  always_ff @(posedge clk) begin
    if (is_access(state_next)) begin
      pad_addr <= cmd_addr;
    end
    if (is_write(state_next)) begin
      pad_wr_data <= cmd_wr_data;
    end
  end

  // enables follow the next state
  // bus drive lasts one extra cycle so write data outlasts the rising edge of we_n
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pad_oe_n  <= 1'b1;
      pad_we_n  <= 1'b1;
      pad_wr_en <= 1'b0;
    end else begin
      pad_oe_n  <= state_next != seq_read;
      pad_we_n  <= !is_write(state_next);
      pad_wr_en <= is_write(state_next) || is_write(state);
    end
  end

  a_we_oe_excl: assert property (@(posedge clk) disable iff (!rst_n)
    pad_we_n || pad_oe_n)
    else $error("pad_we_n and pad_oe_n low together");

  a_ready_gap: assert property (@(posedge clk) disable iff (!rst_n)
    accept |=> !cmd_ready)
    else $error("cmd_ready high right after an acceptance");

endmodule

//--- logic/sram_ctrl_top.sv
`timescale 1ns/1ps

module sram_ctrl_top #(
  parameter int addr_width      = sram_geom_pkg::default_addr_width,
  parameter int data_width      = sram_geom_pkg::default_data_width,
  parameter int fifo_addr_width = sram_geom_pkg::resp_fifo_addr_width
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  input  logic [addr_width-1:0] cmd_addr,
  input  logic                  cmd_wr_en,
  input  logic [data_width-1:0] cmd_wr_data,

  output logic                  resp_rd_valid,
  input  logic                  resp_rd_ready,
  output logic [data_width-1:0] resp_rd_data,

  output logic [addr_width-1:0] sram_io_addr,
  inout  wire  [data_width-1:0] sram_io_data,
  output logic                  sram_io_we_n,
  output logic                  sram_io_oe_n,
  output logic                  sram_io_ce_n
);

  logic [addr_width-1:0] pad_addr;
  logic [data_width-1:0] pad_wr_data;
  logic                  pad_wr_en;
  logic                  pad_we_n;
  logic                  pad_oe_n;
  logic [data_width-1:0] pad_rd_data;
  logic                  pad_rd_valid;
  logic                  fifo_half_full;
  logic                  fifo_r_empty;

  sram_cmd_seq #(
    .addr_width(addr_width),
    .data_width(data_width)
  ) cmd_seq_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_valid     (cmd_valid),
    .cmd_ready     (cmd_ready),
    .cmd_addr      (cmd_addr),
    .cmd_wr_en     (cmd_wr_en),
    .cmd_wr_data   (cmd_wr_data),
    .fifo_half_full(fifo_half_full),
    .pad_addr      (pad_addr),
    .pad_wr_data   (pad_wr_data),
    .pad_wr_en     (pad_wr_en),
    .pad_we_n      (pad_we_n),
    .pad_oe_n      (pad_oe_n)
  );

  sram_pad_io #(
    .addr_width(addr_width),
    .data_width(data_width)
  ) pad_io_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .pad_addr    (pad_addr),
    .pad_wr_data (pad_wr_data),
    .pad_wr_en   (pad_wr_en),
    .pad_we_n    (pad_we_n),
    .pad_oe_n    (pad_oe_n),
    .pad_rd_data (pad_rd_data),
    .pad_rd_valid(pad_rd_valid),
    .sram_io_addr(sram_io_addr),
    .sram_io_data(sram_io_data),
    .sram_io_we_n(sram_io_we_n),
    .sram_io_oe_n(sram_io_oe_n),
    .sram_io_ce_n(sram_io_ce_n)
  );

  sram_resp_fifo #(
    .data_width     (data_width),
    .fifo_addr_width(fifo_addr_width)
  ) resp_fifo_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .w_inc    (pad_rd_valid),
    .w_data   (pad_rd_data),
    .half_full(fifo_half_full),
    .r_inc    (resp_rd_valid && resp_rd_ready),
    .r_data   (resp_rd_data),
    .r_empty  (fifo_r_empty)
  );

  assign resp_rd_valid = !fifo_r_empty;

endmodule

//--- logic/sram_geom_pkg.sv
package sram_geom_pkg;

  // default chip geometry, the top level passes these down as parameters
  parameter int default_addr_width = 4;
  parameter int default_data_width = 16;

  // log2 of the response FIFO depth
  // two reads can sit in the pad pipeline when ready drops at half full,
  // so eight entries leave margin beyond that
  parameter int resp_fifo_addr_width = 3;

endpackage

//--- logic/sram_pad_io.sv
`timescale 1ns/1ps

module sram_pad_io #(
  parameter int addr_width = sram_geom_pkg::default_addr_width,
  parameter int data_width = sram_geom_pkg::default_data_width
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic [addr_width-1:0] pad_addr,
  input  logic [data_width-1:0] pad_wr_data,
  input  logic                  pad_wr_en,
  input  logic                  pad_we_n,
  input  logic                  pad_oe_n,
  output logic [data_width-1:0] pad_rd_data,
  output logic                  pad_rd_valid,

  output logic [addr_width-1:0] sram_io_addr,
  inout  wire  [data_width-1:0] sram_io_data,
  output logic                  sram_io_we_n,
  output logic                  sram_io_oe_n,
  output logic                  sram_io_ce_n
);

  logic [data_width-1:0] wr_data_q;
  logic                  drive_q;
  logic [data_width-1:0] rd_data_q;
  logic                  rd_valid_q;

  // address and write data registers at the pins
  always_ff @(posedge clk) begin
    sram_io_addr <= pad_addr;
    wr_data_q    <= pad_wr_data;
  end

  // strobes and bus drive enable
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sram_io_we_n <= 1'b1;
      sram_io_oe_n <= 1'b1;
      sram_io_ce_n <= 1'b1;
      drive_q      <= 1'b0;
    end else begin
      sram_io_we_n <= pad_we_n;
      sram_io_oe_n <= pad_oe_n;
      // chip selected whenever an access is in progress
      sram_io_ce_n <= pad_we_n && pad_oe_n;
      drive_q      <= pad_wr_en;
    end
  end

  // tristate data bus
  assign sram_io_data = drive_q ? wr_data_q : 'z;

  // sample the bus at the end of the oe_n low cycle
  always_ff @(posedge clk) begin
    if (!sram_io_oe_n) begin
      rd_data_q <= sram_io_data;
    end
  end

  // delayed copy of oe_n marks the captured word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= !sram_io_oe_n;
    end
  end

  assign pad_rd_data  = rd_data_q;
  assign pad_rd_valid = rd_valid_q;

  // the chip drives the bus during a read, a clash would be a contention
  a_no_contention: assert property (@(posedge clk) disable iff (!rst_n)
    !(drive_q && !sram_io_oe_n))
    else $error("data bus driven while sram_io_oe_n is low");

endmodule

//--- logic/sram_resp_fifo.sv
`timescale 1ns/1ps

module sram_resp_fifo #(
  parameter int data_width      = sram_geom_pkg::default_data_width,
  parameter int fifo_addr_width = sram_geom_pkg::resp_fifo_addr_width
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  w_inc,
  input  logic [data_width-1:0] w_data,
  output logic                  half_full,

  input  logic                  r_inc,
  output logic [data_width-1:0] r_data,
  output logic                  r_empty
);

  localparam int depth = 1 << fifo_addr_width;
  localparam logic [fifo_addr_width:0] full_level = (fifo_addr_width + 1)'(depth);
  localparam logic [fifo_addr_width:0] half_level = (fifo_addr_width + 1)'(depth / 2);

  logic [data_width-1:0]    mem [depth];
  logic [fifo_addr_width:0] w_ptr;
  logic [fifo_addr_width:0] r_ptr;
  logic [fifo_addr_width:0] count;
  logic                     full;

  // pointers carry one extra bit so full and empty differ
  assign count     = w_ptr - r_ptr;
  assign full      = count == full_level;
  assign half_full = count >= half_level;
  assign r_empty   = w_ptr == r_ptr;

  // head entry is presented directly
  assign r_data = mem[r_ptr[fifo_addr_width-1:0]];

  always_ff @(posedge clk) begin
    if (w_inc) begin
      mem[w_ptr[fifo_addr_width-1:0]] <= w_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_ptr <= '0;
    end else if (w_inc) begin
      w_ptr <= w_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_ptr <= '0;
    end else if (r_inc) begin
      r_ptr <= r_ptr + 1'b1;
    end
  end

  // reads in flight rely on the sequencer stopping at half full
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    w_inc |-> !full)
    else $error("response FIFO written while full");

  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    r_inc |-> !r_empty)
    else $error("response FIFO read while empty");

endmodule

//--- sram_ctrl_top.f
logic/sram_geom_pkg.sv
logic/sram_cmd_pkg.sv
logic/sram_cmd_seq.sv
logic/sram_pad_io.sv
logic/sram_resp_fifo.sv
logic/sram_ctrl_top.sv
verification/async_sram_model.sv
verification/sram_ctrl_tb.sv

//--- verification/async_sram_model.sv
`timescale 1ns/1ps

module async_sram_model #(
  parameter int addr_width = sram_geom_pkg::default_addr_width,
  parameter int data_width = sram_geom_pkg::default_data_width
) (
  input  logic [addr_width-1:0] addr,
  inout  wire  [data_width-1:0] data,
  input  logic                  we_n,
  input  logic                  oe_n,
  input  logic                  ce_n
);

  logic [data_width-1:0] mem [1 << addr_width];

  // write completes on the rising edge of we_n,
  // the controller keeps ce_n low for the whole strobe
  // and holds the bus one cycle past it
  always_ff @(posedge we_n) begin
    mem[addr] <= data;
  end

  // chip drives the bus only for a selected read
  assign data = (!ce_n && !oe_n && we_n) ? mem[addr] : 'z;

endmodule

//--- verification/sram_ctrl_tb.sv
`timescale 1ns/1ps

module sram_ctrl_tb;
  import sram_geom_pkg::*;
  import sram_cmd_pkg::*;

  localparam int aw    = default_addr_width;
  localparam int dw    = default_data_width;
  localparam int words = 1 << aw;

  // operations per phase
  // the watchdog budget grows with their sum
  localparam int pair_count      = 8;
  localparam int burst_count     = 8;
  localparam int random_count    = 200;
  localparam int stall_reads     = 6;
  localparam int num_ops         = words + 2 * pair_count + burst_count + random_count
                                   + stall_reads;
  localparam int watchdog_cycles = num_ops * 20 + 100;

  logic          clk = 1'b0;
  logic          rst_n;
  logic          cmd_valid;
  logic          cmd_ready;
  logic [aw-1:0] cmd_addr;
  logic          cmd_wr_en;
  logic [dw-1:0] cmd_wr_data;
  logic          resp_rd_valid;
  logic          resp_rd_ready;
  logic [dw-1:0] resp_rd_data;
  logic [aw-1:0] sram_io_addr;
  wire  [dw-1:0] sram_io_data;
  logic          sram_io_we_n;
  logic          sram_io_oe_n;
  logic          sram_io_ce_n;

  int            error_count = 0;
  logic          ready_held;
  logic          ready_random;

  // reference model state
  logic [dw-1:0]           shadow [words];
  logic [dw-1:0]           exp_q [$];
  logic [dw-1:0]           exp_head;
  logic                    exp_empty;
  logic [read_latency-1:0] rd_pipe;
  logic [1:0]              wr_pipe;
  int                      waiting;
  logic [aw-1:0]           acc_addr;
  logic [dw-1:0]           acc_data;

  logic          read_acc;
  logic          write_acc;
  logic          resp_fire;

  assign read_acc  = cmd_valid && cmd_ready && !cmd_wr_en;
  assign write_acc = cmd_valid && cmd_ready && cmd_wr_en;
  assign resp_fire = resp_rd_valid && resp_rd_ready;

  always #4 clk = ~clk;

  sram_ctrl_top #(
    .addr_width     (aw),
    .data_width     (dw),
    .fifo_addr_width(resp_fifo_addr_width)
  ) dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .cmd_addr     (cmd_addr),
    .cmd_wr_en    (cmd_wr_en),
    .cmd_wr_data  (cmd_wr_data),
    .resp_rd_valid(resp_rd_valid),
    .resp_rd_ready(resp_rd_ready),
    .resp_rd_data (resp_rd_data),
    .sram_io_addr (sram_io_addr),
    .sram_io_data (sram_io_data),
    .sram_io_we_n (sram_io_we_n),
    .sram_io_oe_n (sram_io_oe_n),
    .sram_io_ce_n (sram_io_ce_n)
  );

  async_sram_model #(
    .addr_width(aw),
    .data_width(dw)
  ) sram_i (
    .addr(sram_io_addr),
    .data(sram_io_data),
    .we_n(sram_io_we_n),
    .oe_n(sram_io_oe_n),
    .ce_n(sram_io_ce_n)
  );

  task automatic report_error(input string msg);
    error_count++;
    $display("%s", msg);
  endtask

  // step to the next falling edge and redraw ready in the random phase
  task automatic next_fall();
    @(negedge clk);
    if (ready_random) begin
      resp_rd_ready = $urandom_range(3) != 0;
    end
  endtask

  task automatic drive_cmd(input logic wr, input logic [aw-1:0] addr,
                           input logic [dw-1:0] data);
    cmd_valid   = 1'b1;
    cmd_wr_en   = wr;
    cmd_addr    = addr;
    cmd_wr_data = data;
  endtask

  // hold the command until its accepting edge has passed
  task automatic wait_accept();
    while (!cmd_ready) begin
      next_fall();
    end
    next_fall();
    cmd_valid = 1'b0;
  endtask

  task automatic send_cmd(input logic wr, input logic [aw-1:0] addr,
                          input logic [dw-1:0] data);
    drive_cmd(wr, addr, data);
    wait_accept();
  endtask

  task automatic drain();
    while (exp_q.size() != 0) begin
      next_fall();
    end
  endtask

  // shadow memory, expected read data and pin timing of each access
  always @(posedge clk) begin
    if (!rst_n) begin
      rd_pipe <= '0;
      wr_pipe <= '0;
      waiting <= 0;
    end else begin
      rd_pipe <= {rd_pipe[read_latency-2:0], read_acc};
      wr_pipe <= {wr_pipe[0], write_acc};
      // read data lands in the FIFO read_latency edges after acceptance
      waiting <= waiting + int'(rd_pipe[read_latency-1]) - int'(resp_fire);
      if (resp_fire && exp_q.size() != 0) begin
        void'(exp_q.pop_front());
      end
      if (read_acc || write_acc) begin
        acc_addr <= cmd_addr;
        acc_data <= cmd_wr_data;
      end
      if (write_acc) begin
        shadow[cmd_addr] <= cmd_wr_data;
      end
      if (read_acc) begin
        exp_q.push_back(shadow[cmd_addr]);
      end
    end
    exp_empty = exp_q.size() == 0;
    exp_head  = exp_empty ? '0 : exp_q[0];
  end

  a_reset_state: assert property (@(posedge clk) $rose(rst_n) |->
    sram_io_we_n && sram_io_oe_n && sram_io_ce_n && !resp_rd_valid && cmd_ready)
    else report_error($sformatf(
      "FAILED reset state: we_n=%h oe_n=%h ce_n=%h resp_rd_valid=%h cmd_ready=%h",
      $sampled(sram_io_we_n), $sampled(sram_io_oe_n), $sampled(sram_io_ce_n),
      $sampled(resp_rd_valid), $sampled(cmd_ready)));

  a_ready_gap: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid && cmd_ready |=> !cmd_ready)
    else report_error($sformatf("FAILED cmd_ready: got %h after acceptance, expected 0",
      $sampled(cmd_ready)));

  a_resp_expected: assert property (@(posedge clk) disable iff (!rst_n)
    resp_fire |-> !exp_empty)
    else report_error("response returned with no read outstanding");

  a_resp_data: assert property (@(posedge clk) disable iff (!rst_n)
    resp_fire && !exp_empty |-> resp_rd_data == exp_head)
    else report_error($sformatf("FAILED resp_rd_data: got %h expected %h",
      $sampled(resp_rd_data), $sampled(exp_head)));

  a_resp_valid: assert property (@(posedge clk) disable iff (!rst_n)
    resp_rd_valid == (waiting != 0))
    else report_error($sformatf("FAILED resp_rd_valid: got %h expected %h",
      $sampled(resp_rd_valid), $sampled(waiting != 0)));

  // fifo is empty whenever ready has been held high
  a_read_latency: assert property (@(posedge clk) disable iff (!rst_n)
    read_acc && ready_held |-> ##(read_latency + 1) $rose(resp_rd_valid))
    else report_error($sformatf("FAILED resp_rd_valid: %h, no rise %0d cycles after read",
      $sampled(resp_rd_valid), read_latency));

  a_backpressure: assert property (@(posedge clk) disable iff (!rst_n)
    waiting >= 4 |-> !cmd_ready)
    else report_error($sformatf("FAILED cmd_ready: got %h with %0d responses waiting",
      $sampled(cmd_ready), $sampled(waiting)));

  a_resp_stable: assert property (@(posedge clk) disable iff (!rst_n)
    resp_rd_valid && !resp_rd_ready |=> resp_rd_valid && $stable(resp_rd_data))
    else report_error($sformatf("FAILED resp_rd_data: changed to %h while waiting",
      $sampled(resp_rd_data)));

  a_we_window: assert property (@(posedge clk) disable iff (!rst_n)
    sram_io_we_n == !wr_pipe[1])
    else report_error($sformatf("FAILED sram_io_we_n: got %h expected %h",
      $sampled(sram_io_we_n), $sampled(!wr_pipe[1])));

  a_oe_window: assert property (@(posedge clk) disable iff (!rst_n)
    sram_io_oe_n == !rd_pipe[1])
    else report_error($sformatf("FAILED sram_io_oe_n: got %h expected %h",
      $sampled(sram_io_oe_n), $sampled(!rd_pipe[1])));

  a_ce_window: assert property (@(posedge clk) disable iff (!rst_n)
    sram_io_ce_n == !(wr_pipe[1] || rd_pipe[1]))
    else report_error($sformatf("FAILED sram_io_ce_n: got %h expected %h",
      $sampled(sram_io_ce_n), $sampled(!(wr_pipe[1] || rd_pipe[1]))));

  // pins carry the accepted address during every strobe
  a_addr_window: assert property (@(posedge clk) disable iff (!rst_n)
    wr_pipe[1] || rd_pipe[1] |-> sram_io_addr == acc_addr)
    else report_error($sformatf("FAILED sram_io_addr: got %h expected %h",
      $sampled(sram_io_addr), $sampled(acc_addr)));

  a_wr_bus: assert property (@(posedge clk) disable iff (!rst_n)
    wr_pipe[1] |-> sram_io_data == acc_data)
    else report_error($sformatf("FAILED sram_io_data: got %h expected %h",
      $sampled(sram_io_data), $sampled(acc_data)));

  initial begin
    logic [aw-1:0] addr;
    logic          wr;
    int            gap;
    void'($urandom(19146));
    rst_n         = 1'b0;
    cmd_valid     = 1'b0;
    cmd_addr      = '0;
    cmd_wr_en     = 1'b0;
    cmd_wr_data   = '0;
    resp_rd_ready = 1'b1;
    ready_held    = 1'b0;
    ready_random  = 1'b0;
    repeat (3) @(posedge clk);
    next_fall();
    rst_n      = 1'b1;
    ready_held = 1'b1;

    // give every word a known value
    for (int a = 0; a < words; a++) begin
      send_cmd(1'b1, aw'(a), dw'($urandom));
    end
    // write then read back the same word
    for (int i = 0; i < pair_count; i++) begin
      addr = aw'($urandom);
      send_cmd(1'b1, addr, dw'($urandom));
      send_cmd(1'b0, addr, '0);
    end
    // reads back to back with two in the pad pipeline
    for (int i = 0; i < burst_count; i++) begin
      send_cmd(1'b0, aw'(i * 5), '0);
    end
    drain();

    // random mix against a random consumer
    ready_held   = 1'b0;
    ready_random = 1'b1;
    for (int i = 0; i < random_count; i++) begin
      wr  = $urandom_range(1) == 1;
      gap = $urandom_range(2);
      send_cmd(wr, aw'($urandom), dw'($urandom));
      repeat (gap) next_fall();
    end
    ready_random  = 1'b0;
    resp_rd_ready = 1'b1;
    drain();

    // consumer stalls until the sequencer has stopped taking reads
    resp_rd_ready = 1'b0;
    for (int i = 0; i < stall_reads - 1; i++) begin
      send_cmd(1'b0, aw'(i * 3), '0);
    end
    drive_cmd(1'b0, aw'(words - 1), '0);
    repeat (12) next_fall();
    resp_rd_ready = 1'b1;
    wait_accept();
    drain();
    repeat (4) next_fall();

    if (exp_q.size() != 0 || waiting != 0) begin
      report_error($sformatf("%0d responses were never returned", exp_q.size()));
    end
    $display("errors: %0d", error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("run did not finish within %0d cycles, %0d responses still expected",
             watchdog_cycles, exp_q.size());
    $display("errors: %0d", error_count);
    $display("Errors found");
    $finish;
  end

endmodule
